// File: design/scaler_params.svh
`ifndef SCALER_PARAMS_SVH
`define SCALER_PARAMS_SVH

// Pixel word, RGB565
`define SCALER_PIX_W 16

// Size and coordinate values
`define SCALER_RESO_W 10

// Line buffers in the store
`define SCALER_LINES 4

// Weight denominator, whole quarters
`define SCALER_STEPS 4

`endif

// File: design/scaler_pkg.sv
`default_nettype none

`include "scaler_params.svh"

package scaler_pkg;

	// Channel view of one RGB565 word
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// Stream side sees raw, blend side sees rgb
	typedef union packed {
		logic [`SCALER_PIX_W-1:0] raw;
		rgb565_t rgb;
	} pixel_t;

	// Share of the earlier line or column, 0 to 4
	typedef logic [2:0] weight_t;

endpackage

`default_nettype wire

// File: design/line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "scaler_params.svh"

module line_buffer (
	input  logic                      clk,
	input  logic                      i_wr_en,
	input  logic [`SCALER_RESO_W-1:0] i_wr_addr,
	input  logic [`SCALER_PIX_W-1:0]  i_wr_data,
	input  logic                      i_rd_en,
	input  logic [`SCALER_RESO_W-1:0] i_rd_addr,
	output logic [`SCALER_PIX_W-1:0]  o_rd_data
);

	logic [`SCALER_PIX_W-1:0] mem [0:(1 << `SCALER_RESO_W)-1];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// Registered read, holds between strobes
	always_ff @(posedge clk) begin
		if (i_rd_en)
			o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// File: design/line_store.sv
`timescale 1ns/1ns
`default_nettype none

`include "scaler_params.svh"

module line_store (
	input  logic                              clk,
	input  logic                              int_reset,
	input  logic                              i_s_valid,
	input  logic [`SCALER_PIX_W-1:0]          i_s_data,
	input  logic                              i_s_last,
	output logic                              o_s_ready,
	input  logic                              i_release,
	input  logic                              i_rd_en,
	input  logic [`SCALER_RESO_W-1:0]         i_rd_addr,
	input  logic [$clog2(`SCALER_LINES)-1:0]  i_rd_sel_prev,
	input  logic [$clog2(`SCALER_LINES)-1:0]  i_rd_sel_cur,
	output logic [`SCALER_LINES-1:0]          o_line_full,
	output logic [`SCALER_PIX_W-1:0]          o_pix_prev,
	output logic [`SCALER_PIX_W-1:0]          o_pix_cur
);

	localparam int LINES = `SCALER_LINES;

	logic                      s_fire;
	logic [LINES-1:0]          wr_act;
	logic [LINES-1:0]          rel_ptr;
	logic [LINES-1:0]          wr_en_q;
	logic [`SCALER_RESO_W-1:0] wr_addr;
	logic [`SCALER_PIX_W-1:0]  wr_data_q;
	logic                      wr_last_q;
	logic [`SCALER_PIX_W-1:0]  rd_data [LINES];

	assign s_fire = i_s_valid && o_s_ready;

	//////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (s_fire) begin
			wr_data_q <= i_s_data;
			wr_last_q <= i_s_last;
		end
	end

	always_ff @(posedge clk) begin
		if (int_reset)
			wr_en_q <= '0;
		else
			wr_en_q <= s_fire ? wr_act : '0;
	end

	always_ff @(posedge clk) begin
		if (int_reset)
			wr_addr <= '0;
		else if (|wr_en_q)
			wr_addr <= wr_last_q ? '0 : wr_addr + 1'b1;
	end

	// One-hot pointers, rotate per line written / released
	always_ff @(posedge clk) begin
		if (int_reset) begin
			wr_act  <= LINES'(1);
			rel_ptr <= LINES'(1);
		end else begin
			if (s_fire && i_s_last)
				wr_act <= {wr_act[LINES-2:0], wr_act[LINES-1]};
			if (i_release)
				rel_ptr <= {rel_ptr[LINES-2:0], rel_ptr[LINES-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (int_reset)
			o_line_full <= '0;
		else
			o_line_full <= (o_line_full & ~(i_release ? rel_ptr : '0))
				| (wr_last_q ? wr_en_q : '0);
	end

	always_ff @(posedge clk) begin
		if (int_reset)
			o_s_ready <= 1'b0;
		else if (s_fire && i_s_last)
			o_s_ready <= 1'b0;
		else if (!o_s_ready && |(wr_act & ~o_line_full))
			o_s_ready <= 1'b1;
	end

	//////////////////////////////////////////////////////////////
	// Buffers and read mux
	//////////////////////////////////////////////////////////////

	for (genvar i = 0; i < LINES; i++) begin : g_buf
		line_buffer u_buf (
			.clk       (clk),
			.i_wr_en   (wr_en_q[i]),
			.i_wr_addr (wr_addr),
			.i_wr_data (wr_data_q),
			.i_rd_en   (i_rd_en),
			.i_rd_addr (i_rd_addr),
			.o_rd_data (rd_data[i])
		);
	end

	assign o_pix_prev = rd_data[i_rd_sel_prev];
	assign o_pix_cur  = rd_data[i_rd_sel_cur];

endmodule

`default_nettype wire

// File: design/scale_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "scaler_params.svh"

module scale_sequencer (
	input  logic                              clk,
	input  logic                              int_reset,
	input  logic [`SCALER_RESO_W-1:0]         i_src_width,
	input  logic [`SCALER_RESO_W-1:0]         i_src_height,
	input  logic [`SCALER_RESO_W-1:0]         i_dst_width,
	input  logic [`SCALER_RESO_W-1:0]         i_dst_height,
	input  logic [`SCALER_LINES-1:0]          i_line_full,
	output logic                              o_release,
	output logic                              o_rd_en,
	output logic [`SCALER_RESO_W-1:0]         o_rd_addr,
	output logic [$clog2(`SCALER_LINES)-1:0]  o_rd_sel_prev,
	output logic [$clog2(`SCALER_LINES)-1:0]  o_rd_sel_cur,
	output logic                              o_blk_valid,
	output logic                              o_blk_last,
	output scaler_pkg::weight_t               o_blk_wy,
	output scaler_pkg::weight_t               o_blk_wx,
	input  logic                              i_blk_ready
);

	import scaler_pkg::*;

	localparam int RW = `SCALER_RESO_W;
	localparam int MW = 2 * RW + 2;
	localparam int TW = RW + 2;
	localparam int SW = $clog2(`SCALER_LINES);

	localparam logic [2:0] S_WAIT = 3'd0;
	localparam logic [2:0] S_SEEK = 3'd1;
	localparam logic [2:0] S_RD0  = 3'd2;
	localparam logic [2:0] S_RD1  = 3'd3;
	localparam logic [2:0] S_EMIT = 3'd4;
	localparam logic [2:0] S_DONE = 3'd5;

	logic [2:0]              state;
	logic [RW-1:0]           iy_line, oy_line, ix_col, ox_col;
	logic [MW-1:0]           iy_mul, oy_mul, ix_mul, ox_mul;
	logic                    oy_done;
	logic [3:0][TW-1:0]      th_y, th_x;
	logic                    iy_last, oy_last, ix_last, ox_last, iy_first;
	logic                    consume, col_found;
	logic [MW-1:0]           dy, dx;
	logic [SW-1:0]           cur_sel;

	// Count thresholds below the distance
	function automatic weight_t to_weight(input logic [MW-1:0] diff,
			input logic [3:0][TW-1:0] th);
		weight_t w;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			if (diff > MW'(th[i]))
				w = w + 1'b1;
		end
		return w;
	endfunction

	// Quarter points of one destination step, latched in reset
	always_ff @(posedge clk) begin
		if (int_reset) begin
			for (int i = 0; i < 4; i++) begin
				th_y[i] <= TW'((MW'(i_dst_height) * MW'(2 * i + 1)) >> 2);
				th_x[i] <= TW'((MW'(i_dst_width) * MW'(2 * i + 1)) >> 2);
			end
		end
	end

	assign iy_last  = (iy_line == i_src_height - 1'b1);
	assign oy_last  = (oy_line == i_dst_height - 1'b1);
	assign ix_last  = (ix_col == i_src_width - 1'b1);
	assign ox_last  = (ox_col == i_dst_width - 1'b1);
	assign iy_first = (iy_line == '0);

	assign consume   = i_line_full[cur_sel] && !iy_last && (oy_done || iy_mul < oy_mul);
	assign col_found = (ix_mul >= ox_mul) || ix_last;
	assign dy = (iy_mul >= oy_mul) ? iy_mul - oy_mul : '0;
	assign dx = (ix_mul >= ox_mul) ? ix_mul - ox_mul : '0;

	assign cur_sel       = iy_line[SW-1:0];
	assign o_rd_sel_cur  = cur_sel;
	assign o_rd_sel_prev = iy_first ? cur_sel : cur_sel - 1'b1;

	assign o_release   = (state == S_WAIT) && consume && !iy_first;
	assign o_rd_en     = (state == S_RD0) || (state == S_RD1);
	assign o_rd_addr   = (state == S_RD0 && ix_col != '0) ? ix_col - 1'b1 : ix_col;
	assign o_blk_valid = (state == S_EMIT);
	assign o_blk_last  = ox_last;

	//////////////////////////////////////////////////////////////
	// Line and column stepping
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (int_reset) begin
			state   <= S_WAIT;
			iy_line <= '0;
			iy_mul  <= MW'(i_dst_height);
			oy_line <= '0;
			oy_mul  <= MW'(i_src_height);
			oy_done <= 1'b0;
			ix_col  <= '0;
			ix_mul  <= '0;
			ox_col  <= '0;
			ox_mul  <= '0;
			o_blk_wy <= '0;
			o_blk_wx <= '0;
		end else begin
			case (state)
				S_WAIT: begin
					if (consume) begin
						iy_line <= iy_line + 1'b1;
						iy_mul  <= iy_mul + {i_dst_height, 1'b0};
					end else if (i_line_full[cur_sel]) begin
						if (oy_done) begin
							state <= S_DONE;
						end else begin
							// Start an output line on this pair
							o_blk_wy <= iy_first ? '0 : to_weight(dy, th_y);
							ix_col <= '0;
							ix_mul <= MW'(i_dst_width);
							ox_col <= '0;
							ox_mul <= MW'(i_src_width);
							state  <= S_SEEK;
						end
					end
				end
				S_SEEK: begin
					if (col_found) begin
						o_blk_wx <= (ix_col == '0) ? '0 : to_weight(dx, th_x);
						state    <= S_RD0;
					end else begin
						ix_col <= ix_col + 1'b1;
						ix_mul <= ix_mul + {i_dst_width, 1'b0};
					end
				end
				S_RD0: state <= S_RD1;
				S_RD1: state <= S_EMIT;
				S_EMIT: begin
					if (i_blk_ready) begin
						if (ox_last) begin
							oy_line <= oy_line + 1'b1;
							oy_mul  <= oy_mul + {i_src_height, 1'b0};
							oy_done <= oy_last;
							state   <= S_WAIT;
						end else begin
							ox_col <= ox_col + 1'b1;
							ox_mul <= ox_mul + {i_src_width, 1'b0};
							state  <= S_SEEK;
						end
					end
				end
				default: state <= S_DONE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/pixel_blend.sv
`timescale 1ns/1ns
`default_nettype none

`include "scaler_params.svh"

module pixel_blend (
	input  logic                     clk,
	input  logic                     int_reset,
	input  logic                     i_blk_valid,
	output logic                     o_blk_ready,
	input  logic [`SCALER_PIX_W-1:0] i_pix_prev,
	input  logic [`SCALER_PIX_W-1:0] i_pix_cur,
	input  scaler_pkg::weight_t      i_blk_wy,
	input  scaler_pkg::weight_t      i_blk_wx,
	input  logic                     i_blk_last,
	output logic                     o_m_valid,
	output logic [`SCALER_PIX_W-1:0] o_m_data,
	output logic                     o_m_last,
	output logic                     o_m_user,
	input  logic                     i_m_ready
);

	import scaler_pkg::*;

	pixel_t  in_prev, in_cur;
	pixel_t  hist_prev, hist_cur;
	pixel_t  s1_early, s1_late;
	pixel_t  m_pix;
	weight_t s1_wx;
	logic    s1_valid, s1_last;
	logic    s1_ready, s2_ready;

	function automatic logic [5:0] blend_ch(input logic [5:0] e, input logic [5:0] l,
			input weight_t w);
		logic [9:0] acc;
		acc = 10'(e) * 10'(w) + 10'(l) * 10'(3'(`SCALER_STEPS) - w);
		return 6'(acc / `SCALER_STEPS);
	endfunction

	// Channels never mix
	function automatic pixel_t blend_pix(input pixel_t e, input pixel_t l, input weight_t w);
		pixel_t r;
		r.rgb.red   = 5'(blend_ch(6'(e.rgb.red), 6'(l.rgb.red), w));
		r.rgb.green = blend_ch(e.rgb.green, l.rgb.green, w);
		r.rgb.blue  = 5'(blend_ch(6'(e.rgb.blue), 6'(l.rgb.blue), w));
		return r;
	endfunction

	assign in_prev = i_pix_prev;
	assign in_cur  = i_pix_cur;

	assign s2_ready    = !o_m_valid || i_m_ready;
	assign s1_ready    = !s1_valid || s2_ready;
	assign o_blk_ready = s1_ready;

	// Earlier column is whatever sat on the inputs one cycle before
	always_ff @(posedge clk) begin
		if (!(i_blk_valid && !s1_ready)) begin
			hist_prev <= in_prev;
			hist_cur  <= in_cur;
		end
	end

	//////////////////////////////////////////////////////////////
	// Stage one, vertical
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (int_reset)
			s1_valid <= 1'b0;
		else if (s1_ready)
			s1_valid <= i_blk_valid;
	end

	always_ff @(posedge clk) begin
		if (i_blk_valid && s1_ready) begin
			s1_early <= blend_pix(hist_prev, hist_cur, i_blk_wy);
			s1_late  <= blend_pix(in_prev, in_cur, i_blk_wy);
			s1_wx    <= i_blk_wx;
			s1_last  <= i_blk_last;
		end
	end

	//////////////////////////////////////////////////////////////
	// Stage two, horizontal, drives the stream
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (int_reset) begin
			o_m_valid <= 1'b0;
			o_m_last  <= 1'b0;
		end else if (s2_ready) begin
			o_m_valid <= s1_valid;
			if (s1_valid)
				o_m_last <= s1_last;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid && s2_ready)
			m_pix <= blend_pix(s1_early, s1_late, s1_wx);
	end

	assign o_m_data = m_pix.raw;

	always_ff @(posedge clk) begin
		if (int_reset)
			o_m_user <= 1'b1;
		else if (o_m_valid && i_m_ready)
			o_m_user <= 1'b0;
	end

endmodule

`default_nettype wire

// File: design/scaler_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "scaler_params.svh"

module scaler_top (
	input  logic                      clk,
	input  logic                      int_reset,
	input  logic                      i_s_valid,
	input  logic [`SCALER_PIX_W-1:0]  i_s_data,
	input  logic                      i_s_last,
	output logic                      o_s_ready,
	output logic                      o_m_valid,
	output logic [`SCALER_PIX_W-1:0]  o_m_data,
	output logic                      o_m_last,
	output logic                      o_m_user,
	input  logic                      i_m_ready,
	input  logic [`SCALER_RESO_W-1:0] i_src_width,
	input  logic [`SCALER_RESO_W-1:0] i_src_height,
	input  logic [`SCALER_RESO_W-1:0] i_dst_width,
	input  logic [`SCALER_RESO_W-1:0] i_dst_height
);

	import scaler_pkg::*;

	logic [`SCALER_LINES-1:0]         line_full;
	logic                             release_line;
	logic                             rd_en;
	logic [`SCALER_RESO_W-1:0]        rd_addr;
	logic [$clog2(`SCALER_LINES)-1:0] rd_sel_prev, rd_sel_cur;
	logic [`SCALER_PIX_W-1:0]         pix_prev, pix_cur;
	logic                             blk_valid, blk_ready, blk_last;
	weight_t                          blk_wy, blk_wx;

	line_store u_store (
		.clk           (clk),
		.int_reset     (int_reset),
		.i_s_valid     (i_s_valid),
		.i_s_data      (i_s_data),
		.i_s_last      (i_s_last),
		.o_s_ready     (o_s_ready),
		.i_release     (release_line),
		.i_rd_en       (rd_en),
		.i_rd_addr     (rd_addr),
		.i_rd_sel_prev (rd_sel_prev),
		.i_rd_sel_cur  (rd_sel_cur),
		.o_line_full   (line_full),
		.o_pix_prev    (pix_prev),
		.o_pix_cur     (pix_cur)
	);

	scale_sequencer u_seq (
		.clk           (clk),
		.int_reset     (int_reset),
		.i_src_width   (i_src_width),
		.i_src_height  (i_src_height),
		.i_dst_width   (i_dst_width),
		.i_dst_height  (i_dst_height),
		.i_line_full   (line_full),
		.o_release     (release_line),
		.o_rd_en       (rd_en),
		.o_rd_addr     (rd_addr),
		.o_rd_sel_prev (rd_sel_prev),
		.o_rd_sel_cur  (rd_sel_cur),
		.o_blk_valid   (blk_valid),
		.o_blk_last    (blk_last),
		.o_blk_wy      (blk_wy),
		.o_blk_wx      (blk_wx),
		.i_blk_ready   (blk_ready)
	);

	pixel_blend u_blend (
		.clk         (clk),
		.int_reset   (int_reset),
		.i_blk_valid (blk_valid),
		.o_blk_ready (blk_ready),
		.i_pix_prev  (pix_prev),
		.i_pix_cur   (pix_cur),
		.i_blk_wy    (blk_wy),
		.i_blk_wx    (blk_wx),
		.i_blk_last  (blk_last),
		.o_m_valid   (o_m_valid),
		.o_m_data    (o_m_data),
		.o_m_last    (o_m_last),
		.o_m_user    (o_m_user),
		.i_m_ready   (i_m_ready)
	);

endmodule

`default_nettype wire

// File: tests/scaler_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "scaler_params.svh"

module scaler_asserts (
	input logic                     clk,
	input logic                     int_reset,
	input logic                     o_s_ready,
	input logic                     o_m_valid,
	input logic [`SCALER_PIX_W-1:0] o_m_data,
	input logic                     o_m_last,
	input logic                     o_m_user,
	input logic                     i_m_ready
);

	logic seen_xfer;
	int   fail_count = 0;

	// First output transfer of the frame
	always_ff @(posedge clk) begin
		if (int_reset)
			seen_xfer <= 1'b0;
		else if (o_m_valid && i_m_ready)
			seen_xfer <= 1'b1;
	end

	held_while_stalled: assert property (@(posedge clk) disable iff (int_reset)
		o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data) && $stable(o_m_last))
		else begin
			$error("output beat changed while the sink held ready low");
			fail_count++;
		end

	user_on_first_only: assert property (@(posedge clk) disable iff (int_reset)
		o_m_valid && i_m_ready |-> (o_m_user == !seen_xfer))
		else begin
			$error("o_m_user does not mark exactly the first output transfer");
			fail_count++;
		end

	ready_low_after_reset: assert property (@(posedge clk)
		$fell(int_reset) |-> !o_s_ready)
		else begin
			$error("o_s_ready high in the first cycle after reset");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: tests/scaler_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "scaler_params.svh"

module scaler_tb;

	localparam int RW         = `SCALER_RESO_W;
	localparam int PW         = `SCALER_PIX_W;
	localparam int WAIT_LIMIT = 2000;

	logic          clk;
	logic          int_reset;
	logic          i_s_valid;
	logic [PW-1:0] i_s_data;
	logic          i_s_last;
	logic          o_s_ready;
	logic          o_m_valid;
	logic [PW-1:0] o_m_data;
	logic          o_m_last;
	logic          o_m_user;
	logic          i_m_ready;
	logic [RW-1:0] i_src_width;
	logic [RW-1:0] i_src_height;
	logic [RW-1:0] i_dst_width;
	logic [RW-1:0] i_dst_height;

	int            errors;
	int            tests_run;
	int            tests_failed;
	logic [PW-1:0] src_q [$];
	logic [PW-1:0] exp_q [$];

	scaler_top u_dut (
		.clk          (clk),
		.int_reset    (int_reset),
		.i_s_valid    (i_s_valid),
		.i_s_data     (i_s_data),
		.i_s_last     (i_s_last),
		.o_s_ready    (o_s_ready),
		.o_m_valid    (o_m_valid),
		.o_m_data     (o_m_data),
		.o_m_last     (o_m_last),
		.o_m_user     (o_m_user),
		.i_m_ready    (i_m_ready),
		.i_src_width  (i_src_width),
		.i_src_height (i_src_height),
		.i_dst_width  (i_dst_width),
		.i_dst_height (i_dst_height)
	);

	bind scaler_top scaler_asserts u_asserts (
		.clk       (clk),
		.int_reset (int_reset),
		.o_s_ready (o_s_ready),
		.o_m_valid (o_m_valid),
		.o_m_data  (o_m_data),
		.o_m_last  (o_m_last),
		.o_m_user  (o_m_user),
		.i_m_ready (i_m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Sizes are sampled while reset is high
	task automatic apply_reset(input int sw, input int sh, input int dw, input int dh);
		int_reset    = 1'b1;
		i_s_valid    = 1'b0;
		i_s_data     = '0;
		i_s_last     = 1'b0;
		i_m_ready    = 1'b1;
		i_src_width  = RW'(sw);
		i_src_height = RW'(sh);
		i_dst_width  = RW'(dw);
		i_dst_height = RW'(dh);
		repeat (10) @(posedge clk);
		#1;
		int_reset = 1'b0;
	endtask

	task automatic build_frame(input int sw, input int sh, input int dw, input int dh,
			input bit uniform, input logic [PW-1:0] color);
		src_q.delete();
		exp_q.delete();
		for (int y = 0; y < sh; y++) begin
			for (int x = 0; x < sw; x++)
				src_q.push_back(uniform ? color : PW'(y * 256 + x * 5 + 'h3001));
		end
		// Equal sizes give zero weights, so each output is its own source pixel.
		// One color blended with itself at c*w + c*(4-w) over 4 stays c
		for (int i = 0; i < dw * dh; i++)
			exp_q.push_back(uniform ? color : src_q[i]);
	endtask

	task automatic send_frame(input int sw, input int sh, input bit gaps);
		int   cnt;
		logic accepted;
		for (int i = 0; i < sw * sh; i++) begin
			if (gaps) begin
				i_s_valid = 1'b0;
				repeat ($urandom_range(2, 0)) begin
					@(posedge clk);
					#1;
				end
			end
			i_s_valid = 1'b1;
			i_s_data  = src_q[i];
			i_s_last  = ((i + 1) % sw == 0);
			cnt = 0;
			do begin
				@(posedge clk);
				accepted = o_s_ready;
				cnt++;
			end while (!accepted && cnt < WAIT_LIMIT);
			#1;
			if (!accepted) begin
				$display("input stalled: pixel %0d not accepted in %0d cycles", i, WAIT_LIMIT);
				errors++;
				break;
			end
		end
		i_s_valid = 1'b0;
		i_s_last  = 1'b0;
	endtask

	task automatic collect_frame(input int dw, input int dh, input bit rand_ready);
		int   got;
		int   idle;
		logic exp_last;
		logic exp_user;
		got  = 0;
		idle = 0;
		while (got < dw * dh && idle < WAIT_LIMIT) begin
			@(posedge clk);
			if (o_m_valid && i_m_ready) begin
				exp_last = ((got + 1) % dw == 0);
				exp_user = (got == 0);
				if (o_m_data !== exp_q[got]) begin
					$display("mismatch at %0t: o_m_data pixel %0d expected %h got %h",
						$time, got, exp_q[got], o_m_data);
					errors++;
				end
				if (o_m_last !== exp_last) begin
					$display("mismatch at %0t: o_m_last pixel %0d expected %b got %b",
						$time, got, exp_last, o_m_last);
					errors++;
				end
				if (o_m_user !== exp_user) begin
					$display("mismatch at %0t: o_m_user pixel %0d expected %b got %b",
						$time, got, exp_user, o_m_user);
					errors++;
				end
				got++;
				idle = 0;
			end else begin
				idle++;
			end
			#1;
			i_m_ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
		end
		i_m_ready = 1'b1;
		if (got < dw * dh) begin
			$display("output stalled: only %0d of %0d pixels arrived", got, dw * dh);
			errors++;
		end
	endtask

	// Nothing may follow a complete frame
	task automatic check_quiet(input int cycles);
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			if (o_m_valid) begin
				$display("extra output pixel at %0t after the frame was complete", $time);
				errors++;
				break;
			end
		end
		#1;
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (errors != start_errors)
			tests_failed++;
		$display("%-22s %s, %0d errors", name,
			(errors == start_errors) ? "pass" : "fail", errors - start_errors);
	endtask

	//////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		int   start;
		logic ready_seen;
		start      = errors;
		ready_seen = 1'b0;
		apply_reset(8, 4, 8, 4);
		for (int c = 0; c < 20; c++) begin
			@(posedge clk);
			ready_seen = ready_seen | o_s_ready;
			if (o_m_valid !== 1'b0 || o_m_last !== 1'b0) begin
				$display("mismatch at %0t: o_m_valid/o_m_last expected 0/0 got %b/%b",
					$time, o_m_valid, o_m_last);
				errors++;
			end
			if (o_m_user !== 1'b1) begin
				$display("mismatch at %0t: o_m_user expected 1 got %b", $time, o_m_user);
				errors++;
			end
		end
		#1;
		if (!ready_seen) begin
			$display("input ready never rose after reset");
			errors++;
		end
		finish_test("reset_state", start);
	endtask

	task automatic run_frame_test(input string name, input int sw, input int sh,
			input int dw, input int dh, input bit uniform, input logic [PW-1:0] color,
			input bit stress);
		int start;
		start = errors;
		build_frame(sw, sh, dw, dh, uniform, color);
		apply_reset(sw, sh, dw, dh);
		fork
			send_frame(sw, sh, stress);
			collect_frame(dw, dh, stress);
		join
		check_quiet(20);
		finish_test(name, start);
	endtask

	initial begin
		void'($urandom(32'ha05b));
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;

		test_reset_state();
		run_frame_test("identity_8x4", 8, 4, 8, 4, 1'b0, '0, 1'b0);
		run_frame_test("downscale_16x8_to_6x5", 16, 8, 6, 5, 1'b1, 16'hffff, 1'b0);
		run_frame_test("upscale_4x3_to_10x7", 4, 3, 10, 7, 1'b1, 16'hb5d6, 1'b0);
		run_frame_test("backpressure_8x4", 8, 4, 8, 4, 1'b0, '0, 1'b1);

		errors += u_dut.u_asserts.fail_count;
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/scaler_pkg.sv
design/line_buffer.sv
design/line_store.sv
design/scale_sequencer.sv
design/pixel_blend.sv
design/scaler_top.sv
tests/scaler_asserts.sv
tests/scaler_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the scaler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module scaler_tb -f files.f -o Vscaler_tb; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vscaler_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
